/* design/uart_params.svh */
// UART peripheral widths, FIFO depth and bus register map
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// widths and depth
`define UART_DAT_W      8   // character bits
`define UART_BDR_W      8   // baud and sample setting bits
`define UART_FIFO_SIZ   16  // entries per FIFO
`define UART_SYS_DAT_W  32  // bus data
`define UART_SYS_ADR_W  4   // bus address

// register addresses, TX channel
`define UART_ADR_TX_DAT 0   // TX data, write only
`define UART_ADR_TX_CNT 1   // TX FIFO load
`define UART_ADR_TX_BDR 2   // TX bit period minus one
`define UART_ADR_TX_IRQ 4   // TX interrupt limit

// register addresses, RX channel
`define UART_ADR_RX_DAT 8   // RX data, read pops
`define UART_ADR_RX_CNT 9   // RX FIFO load
`define UART_ADR_RX_BDR 10  // RX bit period minus one
`define UART_ADR_RX_SMP 11  // RX sample phase
`define UART_ADR_RX_IRQ 12  // RX interrupt limit

`endif

/* design/uart_pkg.sv */
// shared types of the UART peripheral
// character, baud setting and FIFO load
`include "uart_params.svh"

package uart_pkg;

    ////////////////////
    // payload
    ////////////////////

    // one character on the line, LSB sent first
    typedef logic [`UART_DAT_W-1:0] uart_dat_t;

    ////////////////////
    // configuration
    ////////////////////

    // bit period or sample phase, in clock cycles minus one
    typedef logic [`UART_BDR_W-1:0] uart_bdr_t;

    ////////////////////
    // status
    ////////////////////

    // FIFO load, must hold the full depth too
    typedef logic [$clog2(`UART_FIFO_SIZ+1)-1:0] fifo_cnt_t;

endpackage

/* design/uart_fifo.sv */
// byte FIFO, first word fall through
// register array with read/write pointers and load count
`include "uart_params.svh"

module uart_fifo (
    input  logic                clk,
    input  logic                rst,
    // write side
    input  logic                in_vld,
    input  uart_pkg::uart_dat_t in_dat,
    output logic                in_rdy,   // not full
    // read side
    output logic                out_vld,  // not empty
    output uart_pkg::uart_dat_t out_dat,  // head entry
    input  logic                out_rdy,
    // status
    output uart_pkg::fifo_cnt_t cnt
);
    import uart_pkg::*;

    localparam int unsigned SIZ   = `UART_FIFO_SIZ;
    localparam int unsigned ADR_W = $clog2(SIZ);

    uart_dat_t        mem [SIZ];  // storage
    logic [ADR_W-1:0] wr_ptr;     // next free slot
    logic [ADR_W-1:0] rd_ptr;     // head slot
    logic             push;
    logic             pop;

    // handshakes
    assign in_rdy  = (cnt != fifo_cnt_t'(SIZ));
    assign out_vld = (cnt != '0);
    assign out_dat = mem[rd_ptr];  // head visible while not empty

    assign push = in_vld & in_rdy;
    assign pop  = out_vld & out_rdy;

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_dat;
    end

    ////////////////////
    // pointers, count
    ////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == ADR_W'(SIZ-1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == ADR_W'(SIZ-1)) ? '0 : rd_ptr + 1'b1;
            // simultaneous push and pop keeps the load
            case ({push, pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

endmodule

/* design/uart_ser.sv */
// UART TX serializer
// 1 start, 8 data LSB first, 1 stop; bit period is cfg_bdr+1 cycles

module uart_ser (
    input  logic                clk,
    input  logic                rst,
    // configuration
    input  uart_pkg::uart_bdr_t cfg_bdr,  // bit period minus one
    // byte stream in
    input  logic                str_vld,
    input  uart_pkg::uart_dat_t str_dat,
    output logic                str_rdy,  // idle
    // serial line
    output logic                txd
);
    import uart_pkg::*;

    localparam int unsigned FRM_W = $bits(uart_dat_t) + 2;  // start + data + stop
    localparam int unsigned CNT_W = $clog2(FRM_W + 1);

    uart_bdr_t        bdr_cnt;  // cycles left in current bit
    logic [CNT_W-1:0] bit_cnt;  // bits left in frame, zero when idle
    logic [FRM_W-1:0] shr;      // frame shift register, bit 0 on the line

    assign str_rdy = (bit_cnt == '0);
    assign txd     = shr[0];  // ones shifted in keep the line high

    ////////////////////
    // frame shifter
    ////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bdr_cnt <= '0;
            bit_cnt <= '0;
            shr     <= '1;  // line idles high
        end else if (str_rdy) begin
            // load a new frame only between frames
            if (str_vld) begin
                shr     <= {1'b1, str_dat, 1'b0};  // stop, data, start
                bit_cnt <= CNT_W'(FRM_W);
                bdr_cnt <= cfg_bdr;
            end
        end else if (bdr_cnt == '0) begin
            // end of bit period, next bit
            shr     <= {1'b1, shr[FRM_W-1:1]};
            bit_cnt <= bit_cnt - 1'b1;
            bdr_cnt <= cfg_bdr;
        end else begin
            bdr_cnt <= bdr_cnt - 1'b1;
        end
    end

endmodule

/* design/uart_des.sv */
// UART RX deserializer
// two-flop synchronizer, start edge detect, programmable sample phase
// start recheck and stop check, one cycle vld per good frame

module uart_des (
    input  logic                clk,
    input  logic                rst,
    // configuration
    input  uart_pkg::uart_bdr_t cfg_bdr,  // bit period minus one
    input  uart_pkg::uart_bdr_t cfg_smp,  // first sample delay minus one
    // byte stream out, no backpressure
    output logic                str_vld,
    output uart_pkg::uart_dat_t str_dat,
    // serial line
    input  logic                rxd
);
    import uart_pkg::*;

    localparam int unsigned DAT_W = $bits(uart_dat_t);
    localparam int unsigned CNT_W = $clog2(DAT_W + 2);
    localparam logic [CNT_W-1:0] STP = CNT_W'(DAT_W + 1);  // stop bit index

    logic             rxd_m, rxd_s, rxd_d;  // sync stages, previous value
    logic             fall;                 // falling edge on synced line
    logic             run;                  // frame in progress
    uart_bdr_t        phs;                  // cycles to next sample
    logic [CNT_W-1:0] bit_cnt;              // 0 start, 1..DAT_W data, STP stop
    logic             smp;                  // sample strobe
    uart_dat_t        shr;                  // data shift register

    ////////////////////
    // synchronizer
    ////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rxd_m <= 1'b1;
            rxd_s <= 1'b1;
            rxd_d <= 1'b1;
        end else begin
            rxd_m <= rxd;
            rxd_s <= rxd_m;
            rxd_d <= rxd_s;
        end
    end

    assign fall = rxd_d & ~rxd_s;
    assign smp  = run & (phs == '0);

    ////////////////////
    // frame control
    ////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            run     <= 1'b0;
            phs     <= '0;
            bit_cnt <= '0;
            str_vld <= 1'b0;
            str_dat <= '0;
        end else begin
            str_vld <= 1'b0;  // pulse
            if (!run) begin
                if (fall) begin
                    run     <= 1'b1;
                    phs     <= cfg_smp;
                    bit_cnt <= '0;
                end
            end else if (!smp) begin
                phs <= phs - 1'b1;
            end else begin
                phs     <= cfg_bdr;
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == '0) begin
                    if (rxd_s) run <= 1'b0;  // start glitch, back to idle
                end else if (bit_cnt == STP) begin
                    run <= 1'b0;
                    // low stop sample drops the frame
                    if (rxd_s) begin
                        str_vld <= 1'b1;
                        str_dat <= shr;
                    end
                end
            end
        end
    end

    // data bits enter at the top, LSB ends at bit 0
    always_ff @(posedge clk) begin
        if (smp && (bit_cnt != '0) && (bit_cnt != STP)) shr <= {rxd_s, shr[DAT_W-1:1]};
    end

endmodule

/* design/uart_dev.sv */
// UART peripheral top level
// register map, bus decode, level interrupts, TX and RX channels
`include "uart_params.svh"

module uart_dev (
    // serial lines
    input  logic                       uart_rxd,
    output logic                       uart_txd,
    // system
    input  logic                       clk,
    input  logic                       rst,
    // bus write
    input  logic                       sys_wen,
    input  logic [`UART_SYS_ADR_W-1:0] sys_wad,
    input  logic [`UART_SYS_DAT_W-1:0] sys_wdt,
    // bus read, rdt combinational from rad
    input  logic                       sys_ren,
    input  logic [`UART_SYS_ADR_W-1:0] sys_rad,
    output logic [`UART_SYS_DAT_W-1:0] sys_rdt,
    // interrupts
    output logic                       irq_tx,  // TX load below limit
    output logic                       irq_rx   // RX load above limit
);
    import uart_pkg::*;

    localparam int unsigned DW = `UART_SYS_DAT_W;
    localparam int unsigned CW = $bits(fifo_cnt_t);

    uart_bdr_t tx_cfg_bdr, rx_cfg_bdr;  // bit periods
    uart_bdr_t rx_cfg_smp;              // RX sample phase
    fifo_cnt_t tx_cfg_irq, rx_cfg_irq;  // interrupt limits
    fifo_cnt_t tx_sts_cnt, rx_sts_cnt;  // FIFO loads

    // bus side streams
    logic      tx_bus_vld, tx_bus_rdy;
    uart_dat_t tx_bus_dat;
    logic      rx_bus_vld, rx_bus_rdy;
    uart_dat_t rx_bus_dat;

    // line side streams
    logic      tx_str_vld, tx_str_rdy;
    uart_dat_t tx_str_dat;
    logic      rx_str_vld, rx_str_rdy;
    uart_dat_t rx_str_dat;

    ////////////////////
    // bus read
    ////////////////////

    always_comb begin
        case (sys_rad)
            `UART_ADR_TX_CNT: sys_rdt = DW'(tx_sts_cnt);
            `UART_ADR_TX_BDR: sys_rdt = DW'(tx_cfg_bdr);
            `UART_ADR_TX_IRQ: sys_rdt = DW'(tx_cfg_irq);
            `UART_ADR_RX_DAT: sys_rdt = rx_bus_vld ? DW'(rx_bus_dat) : '0;  // empty reads zero
            `UART_ADR_RX_CNT: sys_rdt = DW'(rx_sts_cnt);
            `UART_ADR_RX_BDR: sys_rdt = DW'(rx_cfg_bdr);
            `UART_ADR_RX_SMP: sys_rdt = DW'(rx_cfg_smp);
            `UART_ADR_RX_IRQ: sys_rdt = DW'(rx_cfg_irq);
            default:          sys_rdt = '0;  // TX data and holes
        endcase
    end

    assign rx_bus_rdy = sys_ren & (sys_rad == `UART_SYS_ADR_W'(`UART_ADR_RX_DAT));  // pop

    ////////////////////
    // bus write
    ////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            tx_cfg_bdr <= '0;
            tx_cfg_irq <= '0;
            rx_cfg_bdr <= '0;
            rx_cfg_smp <= '0;
            rx_cfg_irq <= '0;
        end else if (sys_wen) begin
            case (sys_wad)
                `UART_ADR_TX_BDR: tx_cfg_bdr <= sys_wdt[`UART_BDR_W-1:0];
                `UART_ADR_TX_IRQ: tx_cfg_irq <= sys_wdt[CW-1:0];
                `UART_ADR_RX_BDR: rx_cfg_bdr <= sys_wdt[`UART_BDR_W-1:0];
                `UART_ADR_RX_SMP: rx_cfg_smp <= sys_wdt[`UART_BDR_W-1:0];
                `UART_ADR_RX_IRQ: rx_cfg_irq <= sys_wdt[CW-1:0];
                default: ;  // read only or unmapped
            endcase
        end
    end

    // TX data push, full FIFO drops the byte
    assign tx_bus_vld = sys_wen & (sys_wad == `UART_SYS_ADR_W'(`UART_ADR_TX_DAT)) & tx_bus_rdy;
    assign tx_bus_dat = sys_wdt[`UART_DAT_W-1:0];

    ////////////////////
    // TX channel
    ////////////////////

    uart_fifo tx_fifo (
        .clk     (clk),
        .rst     (rst),
        .in_vld  (tx_bus_vld),
        .in_dat  (tx_bus_dat),
        .in_rdy  (tx_bus_rdy),
        .out_vld (tx_str_vld),
        .out_dat (tx_str_dat),
        .out_rdy (tx_str_rdy),
        .cnt     (tx_sts_cnt)
    );

    uart_ser tx_ser (
        .clk     (clk),
        .rst     (rst),
        .cfg_bdr (tx_cfg_bdr),
        .str_vld (tx_str_vld),
        .str_dat (tx_str_dat),
        .str_rdy (tx_str_rdy),
        .txd     (uart_txd)
    );

    assign irq_tx = (tx_sts_cnt < tx_cfg_irq);

    ////////////////////
    // RX channel
    ////////////////////

    uart_des rx_des (
        .clk     (clk),
        .rst     (rst),
        .cfg_bdr (rx_cfg_bdr),
        .cfg_smp (rx_cfg_smp),
        .str_vld (rx_str_vld),
        .str_dat (rx_str_dat),
        .rxd     (uart_rxd)
    );

    // deserializer cannot stall, byte lost when full
    uart_fifo rx_fifo (
        .clk     (clk),
        .rst     (rst),
        .in_vld  (rx_str_vld & rx_str_rdy),
        .in_dat  (rx_str_dat),
        .in_rdy  (rx_str_rdy),
        .out_vld (rx_bus_vld),
        .out_dat (rx_bus_dat),
        .out_rdy (rx_bus_rdy),
        .cnt     (rx_sts_cnt)
    );

    assign irq_rx = (rx_sts_cnt > rx_cfg_irq);

endmodule

/* testbench/uart_checker.sv */
// checker for the UART peripheral testbench
// decodes the TX line, models both FIFOs and the registers,
// checks every bus read and the interrupts, counts errors
`include "uart_params.svh"

module uart_checker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       uart_txd,
    input  logic                       uart_rxd,
    input  logic                       sys_wen,
    input  logic [`UART_SYS_ADR_W-1:0] sys_wad,
    input  logic [`UART_SYS_DAT_W-1:0] sys_wdt,
    input  logic                       sys_ren,
    input  logic [`UART_SYS_ADR_W-1:0] sys_rad,
    input  logic [`UART_SYS_DAT_W-1:0] sys_rdt,
    input  logic                       irq_tx,
    input  logic                       irq_rx,
    output logic                       busy,  // accepted bytes not yet off the line
    output int                         err_reg,
    output int                         err_tx,
    output int                         err_rx,
    output int                         err_irq
);
    import uart_pkg::*;

    localparam int SIZ = `UART_FIFO_SIZ;

    uart_dat_t tx_q[$];          // accepted bytes in order with the serializer byte at the head
    uart_dat_t rx_q[$];          // RX FIFO model
    uart_bdr_t tx_bdr, rx_bdr, rx_smp;
    fifo_cnt_t tx_lim, rx_lim;
    logic      in_frm;           // decoding a frame
    int        cyc;              // cycles since start bit seen
    int        per;              // bit period of this frame
    uart_dat_t shr;              // decoded data bits

    task automatic value_error(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("Error at time %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    endtask

    always @(posedge clk) begin
        logic [31:0] exp;
        int          tx_cnt;
        int          idx;
        if (rst) begin
            tx_q.delete();
            rx_q.delete();
            {tx_bdr, rx_bdr, rx_smp, tx_lim, rx_lim} = '0;
            in_frm  = 1'b0;
            cyc     = 0;
            per     = 1;
            err_reg = 0;
            err_tx  = 0;
            err_rx  = 0;
            err_irq = 0;
            busy   <= 1'b0;
        end else begin
            ////////////////////
            // TX line decode
            ////////////////////
            if (!in_frm && !uart_txd) begin
                // serializer took the head byte one edge ago
                if (tx_q.size() == 0) begin
                    err_tx++;
                    $display("Error at time %0t: frame on the TX line with no byte written",
                             $time);
                end
                in_frm = 1'b1;
                cyc    = 0;
                per    = int'(tx_bdr) + 1;
            end else if (in_frm) begin
                cyc++;
            end
            if (in_frm && (cyc % per == per / 2)) begin  // middle of a bit
                idx = cyc / per;
                if (idx == 0) begin
                    if (uart_txd) begin
                        err_tx++;
                        value_error("start bit", 32'(uart_txd), 32'(0));
                    end
                end else if (idx <= 8) begin
                    shr[idx-1] = uart_txd;  // LSB first
                end else begin
                    in_frm = 1'b0;
                    if (!uart_txd) begin
                        err_tx++;
                        value_error("stop bit", 32'(uart_txd), 32'(1));
                    end
                    if (tx_q.size() != 0) begin
                        exp = 32'(tx_q.pop_front());
                        if (32'(shr) !== exp) begin
                            err_tx++;
                            value_error("TX line byte", 32'(shr), exp);
                        end
                        // receiver keeps the byte on a high stop bit when the RX FIFO has room
                        if (uart_rxd && rx_q.size() < SIZ) rx_q.push_back(shr);
                    end
                end
            end
            tx_cnt = tx_q.size() - int'(in_frm);  // serializer byte left the FIFO

            ////////////////////
            // bus reads
            ////////////////////
            if (sys_ren) begin
                exp = '0;
                case (sys_rad)
                    `UART_ADR_TX_CNT: exp = 32'(tx_cnt);
                    `UART_ADR_TX_BDR: exp = 32'(tx_bdr);
                    `UART_ADR_TX_IRQ: exp = 32'(tx_lim);
                    `UART_ADR_RX_DAT: if (rx_q.size() != 0) exp = 32'(rx_q.pop_front());
                    `UART_ADR_RX_CNT: exp = 32'(rx_q.size());
                    `UART_ADR_RX_BDR: exp = 32'(rx_bdr);
                    `UART_ADR_RX_SMP: exp = 32'(rx_smp);
                    `UART_ADR_RX_IRQ: exp = 32'(rx_lim);
                    default: ;  // TX data and holes read zero
                endcase
                if (sys_rdt !== exp) begin
                    if (sys_rad == `UART_SYS_ADR_W'(`UART_ADR_RX_DAT)) err_rx++;
                    else err_reg++;
                    value_error($sformatf("read of address %0d", sys_rad), sys_rdt, exp);
                end
                // interrupts against the model count of this read
                if (sys_rad == `UART_SYS_ADR_W'(`UART_ADR_TX_CNT) &&
                    irq_tx !== (exp < 32'(tx_lim))) begin
                    err_irq++;
                    value_error("irq_tx", 32'(irq_tx), 32'(exp < 32'(tx_lim)));
                end
                if (sys_rad == `UART_SYS_ADR_W'(`UART_ADR_RX_CNT) &&
                    irq_rx !== (exp > 32'(rx_lim))) begin
                    err_irq++;
                    value_error("irq_rx", 32'(irq_rx), 32'(exp > 32'(rx_lim)));
                end
            end

            ////////////////////
            // bus writes
            ////////////////////
            if (sys_wen) begin
                case (sys_wad)
                    `UART_ADR_TX_DAT: if (tx_cnt < SIZ) tx_q.push_back(sys_wdt[7:0]);
                    `UART_ADR_TX_BDR: tx_bdr = sys_wdt[7:0];
                    `UART_ADR_TX_IRQ: tx_lim = sys_wdt[4:0];
                    `UART_ADR_RX_BDR: rx_bdr = sys_wdt[7:0];
                    `UART_ADR_RX_SMP: rx_smp = sys_wdt[7:0];
                    `UART_ADR_RX_IRQ: rx_lim = sys_wdt[4:0];
                    default: ;
                endcase
            end
            busy <= (tx_q.size() != 0);
        end
    end

endmodule

/* testbench/uart_tb.sv */
// testbench top for the UART peripheral
// clock, reset, LFSR stimulus, bus tasks, TX to RX loopback,
// watchdog and closing report
`include "uart_params.svh"

module uart_tb;

    localparam int CLK_PER = 100;
    localparam int N_BYTES = 12;   // loopback bytes, fits both FIFOs
    localparam int N_OVF   = 20;   // back to back writes in the overflow test
    localparam int MAX_BIT = 256;  // largest bit period in cycles
    localparam int TIMEOUT = (N_BYTES + N_OVF) * 10 * MAX_BIT + 5000;  // cycles

    logic                       clk;
    logic                       rst;
    logic                       loop_line;  // uart_txd back into uart_rxd
    logic                       sys_wen;
    logic [`UART_SYS_ADR_W-1:0] sys_wad;
    logic [`UART_SYS_DAT_W-1:0] sys_wdt;
    logic                       sys_ren;
    logic [`UART_SYS_ADR_W-1:0] sys_rad;
    logic [`UART_SYS_DAT_W-1:0] sys_rdt;
    logic                       irq_tx, irq_rx;
    logic                       busy;
    int                         err_reg, err_tx, err_rx, err_irq;
    logic [15:0]                lfsr = 16'd87;

    uart_dev uart_dev_inst (
        .uart_rxd (loop_line),
        .uart_txd (loop_line),
        .clk      (clk),
        .rst      (rst),
        .sys_wen  (sys_wen),
        .sys_wad  (sys_wad),
        .sys_wdt  (sys_wdt),
        .sys_ren  (sys_ren),
        .sys_rad  (sys_rad),
        .sys_rdt  (sys_rdt),
        .irq_tx   (irq_tx),
        .irq_rx   (irq_rx)
    );

    uart_checker uart_checker_inst (
        .clk (clk), .rst (rst), .uart_txd (loop_line), .uart_rxd (loop_line),
        .sys_wen (sys_wen), .sys_wad (sys_wad), .sys_wdt (sys_wdt),
        .sys_ren (sys_ren), .sys_rad (sys_rad), .sys_rdt (sys_rdt),
        .irq_tx (irq_tx), .irq_rx (irq_rx), .busy (busy),
        .err_reg (err_reg), .err_tx (err_tx), .err_rx (err_rx), .err_irq (err_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PER / 2) clk = ~clk;
    end

    ////////////////////
    // stimulus helpers
    ////////////////////

    // 16 bit Fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};  // one step per bit
        end
    endtask

    // called at a rising edge, returns at the edge that takes the write
    task automatic bus_write(input int adr, input logic [31:0] dat);
        sys_wen <= 1'b1;
        sys_wad <= adr[`UART_SYS_ADR_W-1:0];
        sys_wdt <= dat;
        @(posedge clk);
        sys_wen <= 1'b0;
    endtask

    task automatic bus_read(input int adr, output logic [31:0] dat);
        sys_ren <= 1'b1;
        sys_rad <= adr[`UART_SYS_ADR_W-1:0];
        @(negedge clk);
        dat = sys_rdt;  // settled before the edge
        @(posedge clk);
        sys_ren <= 1'b0;
    endtask

    task automatic set_limits();
        logic [31:0] v;
        rand_bits(5, v);
        bus_write(`UART_ADR_TX_IRQ, v % 17);  // 0..16
        rand_bits(5, v);
        bus_write(`UART_ADR_RX_IRQ, v % 17);
    endtask

    // poll TX load until the line is done, then let RX catch up
    task automatic drain_tx(input int bdr);
        logic [31:0] v;
        do begin
            bus_read(`UART_ADR_TX_CNT, v);
        end while (busy);
        repeat (bdr + 9) @(posedge clk);  // stop bit, sync and FIFO delay
    endtask

    task automatic drain_rx();
        logic [31:0] n;
        logic [31:0] v;
        bus_read(`UART_ADR_RX_CNT, n);
        repeat (n) bus_read(`UART_ADR_RX_DAT, v);
        bus_read(`UART_ADR_RX_CNT, n);  // back to empty
    endtask

    // watchdog, sized for every byte at the slowest bit period
    initial begin
        #(TIMEOUT * CLK_PER);
        $display("run timed out after %0d cycles, the DUT stopped making progress", TIMEOUT);
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        logic [31:0] v;
        logic [31:0] bdr;
        rst     = 1'b1;
        sys_wen = 1'b0;
        sys_wad = '0;
        sys_wdt = '0;
        sys_ren = 1'b0;
        sys_rad = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // reset values, random config, readback of the whole map
        for (int a = 0; a < 16; a++)
            bus_read(a, v);
        rand_bits(32, v);
        bus_write(`UART_ADR_TX_BDR, v);
        rand_bits(32, v);
        bus_write(`UART_ADR_TX_IRQ, v);
        rand_bits(32, v);
        bus_write(`UART_ADR_RX_BDR, v);
        rand_bits(32, v);
        bus_write(`UART_ADR_RX_SMP, v);
        rand_bits(32, v);
        bus_write(`UART_ADR_RX_IRQ, v);
        for (int a = 0; a < 16; a++)
            bus_read(a, v);

        // framing and loopback, random baud 8..39
        rand_bits(5, bdr);
        bdr = bdr + 8;
        bus_write(`UART_ADR_TX_BDR, bdr);
        bus_write(`UART_ADR_RX_BDR, bdr);
        bus_write(`UART_ADR_RX_SMP, bdr / 2);  // mid bit
        set_limits();
        repeat (N_BYTES) begin
            rand_bits(8, v);
            bus_write(`UART_ADR_TX_DAT, v);
        end
        drain_tx(bdr);
        drain_rx();

        // TX overflow at the slowest baud
        bus_write(`UART_ADR_TX_BDR, 255);
        bus_write(`UART_ADR_RX_BDR, 255);
        bus_write(`UART_ADR_RX_SMP, 127);
        set_limits();
        repeat (N_OVF) begin
            rand_bits(8, v);
            bus_write(`UART_ADR_TX_DAT, v);
        end
        drain_tx(255);
        drain_rx();

        // interrupt limits against idle counts
        repeat (4) begin
            set_limits();
            bus_read(`UART_ADR_TX_CNT, v);
            bus_read(`UART_ADR_RX_CNT, v);
        end

        repeat (4) @(posedge clk);
        $display("errors: register %0d, tx line %0d, rx data %0d, interrupt %0d",
                 err_reg, err_tx, err_rx, err_irq);
        if (err_reg + err_tx + err_rx + err_irq == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+design
design/uart_pkg.sv
design/uart_fifo.sv
design/uart_ser.sv
design/uart_des.sv
design/uart_dev.sv
testbench/uart_checker.sv
testbench/uart_tb.sv

/* Makefile */
# Verilator build and run of the UART peripheral testbench

TOP       ?= uart_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 -Wno-fatal
PASS_MSG  ?= TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status follows the pass line in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
